/* dv/rv_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_assertions (
    input wire logic                    clk,
    input wire logic                    arst_n,
    input wire logic                    io_req,
    input wire logic                    io_ack,
    input wire logic [rv_pkg::xlen-1:0] io_data,
    input wire logic                    stall,
    input wire logic                    flush
);

    int failures = 0;

    // the payload may not move while a request is outstanding.
    a_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        io_req |=> (!io_req || $stable(io_data)))
    else begin
        failures++;
        $error("io_data changed while io_req was high");
    end

    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (io_req && !io_ack) |=> io_req)
    else begin
        failures++;
        $error("io_req dropped before io_ack was seen");
    end

    // a new request only starts once the previous ack has gone low.
    a_no_rise_on_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (!io_req && io_ack) |=> !io_req)
    else begin
        failures++;
        $error("io_req rose while io_ack was high");
    end

    a_flush_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !(flush && stall))
    else begin
        failures++;
        $error("flush and stall were high together");
    end

endmodule

`default_nettype wire

/* dv/rv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_tb;

    localparam int imem_depth = rv_pkg::imem_depth_default;
    localparam int aw = $clog2(imem_depth);
    localparam int wait_limit = 200;

    logic                    clk;
    logic                    arst_n;
    logic                    run;
    logic                    imem_we;
    logic [aw-1:0]           imem_addr;
    logic [rv_pkg::xlen-1:0] imem_wdata;
    logic                    io_ack;
    logic                    io_req;
    logic [rv_pkg::xlen-1:0] io_data;
    logic [rv_pkg::xlen-1:0] pc_out;

    logic [rv_pkg::xlen-1:0] prog[$];
    logic [rv_pkg::xlen-1:0] expect_q[$];
    logic [rv_pkg::xlen-1:0] got[$];
    int                      errors = 0;
    int                      checks = 0;

    rv_core_top #(
        .IMEM_DEPTH (imem_depth)
    ) dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .io_ack     (io_ack),
        .io_req     (io_req),
        .io_data    (io_data),
        .pc_out     (pc_out)
    );

    bind rv_core_top rv_assertions u_assertions (
        .clk     (clk),
        .arst_n  (arst_n),
        .io_req  (io_req),
        .io_ack  (io_ack),
        .io_data (io_data),
        .stall   (x_if.stall),
        .flush   (x_if.flush)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // instruction encoders and reference helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] branch(input logic ne, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, {2'b00, ne}, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // a negative value is below any non-negative one; equal signs order like unsigned.
    function automatic logic [31:0] slt_ref(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) begin
            return {31'd0, a[31]};
        end
        return (a < b) ? 32'd1 : 32'd0;
    endfunction

    // x31 holds the port address in every program.
    task automatic emit_store(input logic [4:0] rs2);
        prog.push_back(sw(rs2, 5'd31, 12'd0));
    endtask

    task automatic start_program();
        prog.delete();
        expect_q.delete();
        prog.push_back(addi(5'd31, 5'd0, 12'h100));
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input int idx,
                              input logic [rv_pkg::xlen-1:0] exp,
                              input logic [rv_pkg::xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s store %0d: expected %h, actual %h", name, idx, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s store count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [rv_pkg::xlen-1:0] exp,
                            input logic [rv_pkg::xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s pc: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // program load and output port responder
    // ------------------------------------------------------------------------

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i[aw-1:0];
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic serve_store(input string name, output bit ok);
        int cycles;
        int delay;
        ok = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!io_req && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!io_req) begin
            errors++;
            $display("%s: timed out waiting for an output request", name);
            return;
        end
        got.push_back(io_data);
        delay = int'($urandom_range(5, 0));
        repeat (delay) @(negedge clk);
        @(posedge clk);
        io_ack <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (io_req && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (io_req) begin
            errors++;
            $display("%s: output request stayed high after the ack", name);
        end
        delay = int'($urandom_range(5, 0));
        repeat (delay) @(negedge clk);
        @(posedge clk);
        io_ack <= 1'b0;
        ok = !io_req;
    endtask

    task automatic run_program(input string name);
        bit                      ok;
        int                      n;
        int                      cycles;
        logic [rv_pkg::xlen-1:0] final_pc;
        final_pc = (prog.size() - 1) * 4;
        load_program();
        got.delete();
        @(posedge clk);
        run <= 1'b1;
        ok = 1'b1;
        while (ok && got.size() < expect_q.size()) begin
            serve_store(name, ok);
        end
        // stores beyond the expected ones would show up in this window.
        for (int i = 0; i < 30; i++) begin
            @(negedge clk);
            if (ok && io_req) begin
                serve_store(name, ok);
            end
        end
        // the closing jump to itself leaves the PC alternating between it and the next word.
        cycles = 0;
        while (pc_out !== final_pc && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        check_pc(name, final_pc, pc_out);
        check_count(name, expect_q.size(), got.size());
        n = (got.size() < expect_q.size()) ? got.size() : expect_q.size();
        for (int i = 0; i < n; i++) begin
            check_word(name, i, expect_q[i], got[i]);
        end
        @(posedge clk);
        run <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_pc(name, 32'd0, pc_out);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic test_arith();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = $urandom();
        a = sext12(r[11:0]);
        b = sext12(r[27:16]);
        start_program();
        prog.push_back(addi(5'd1, 5'd0, 12'hff9));
        prog.push_back(addi(5'd2, 5'd0, 12'd100));
        prog.push_back(addi(5'd3, 5'd0, r[11:0]));
        prog.push_back(addi(5'd4, 5'd0, r[27:16]));
        emit_store(5'd1);
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
        emit_store(5'd5);
        prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd6));
        emit_store(5'd6);
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd7));
        emit_store(5'd7);
        prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        emit_store(5'd8);
        prog.push_back(r_type(7'h00, 5'd4, 5'd3, 3'b000, 5'd9));
        emit_store(5'd9);
        prog.push_back(r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd10));
        emit_store(5'd10);
        prog.push_back(r_type(7'h00, 5'd4, 5'd3, 3'b010, 5'd11));
        emit_store(5'd11);
        prog.push_back(jal(5'd0, 21'd0));
        expect_q = '{32'hffff_fff9, 32'd93, 32'hffff_ff95, 32'd1, 32'd0,
                     a + b, a - b, slt_ref(a, b)};
        run_program("arith");
    endtask

    task automatic test_logic();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = $urandom();
        a = {r[31:12], 12'h000};
        b = sext12(r[11:0]);
        start_program();
        prog.push_back(lui(5'd1, r[31:12]));
        emit_store(5'd1);
        prog.push_back(addi(5'd2, 5'd0, r[11:0]));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
        emit_store(5'd3);
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd4));
        emit_store(5'd4);
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        emit_store(5'd5);
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        emit_store(5'd0);
        prog.push_back(jal(5'd0, 21'd0));
        expect_q = '{a, a & b, a | b, a ^ b, 32'd0};
        run_program("logic");
    endtask

    task automatic test_deps();
        start_program();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd1));
        prog.push_back(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd1));
        prog.push_back(addi(5'd2, 5'd1, 12'd3));
        prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b100, 5'd3));
        prog.push_back(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
        emit_store(5'd4);
        emit_store(5'd3);
        emit_store(5'd1);
        prog.push_back(jal(5'd0, 21'd0));
        // 5 doubled twice is 20, plus 3 is 23, 23 ^ 20 is 3, and 3 - 23 is -20.
        expect_q = '{32'hffff_ffec, 32'd3, 32'd20};
        run_program("deps");
    endtask

    task automatic test_branch();
        start_program();
        prog.push_back(addi(5'd1, 5'd0, 12'd3));
        prog.push_back(addi(5'd2, 5'd0, 12'd3));
        prog.push_back(branch(1'b0, 5'd1, 5'd2, 13'd8));
        emit_store(5'd31);
        prog.push_back(branch(1'b1, 5'd1, 5'd2, 13'd8));
        prog.push_back(addi(5'd5, 5'd0, 12'd11));
        emit_store(5'd5);
        prog.push_back(addi(5'd2, 5'd0, 12'd4));
        prog.push_back(branch(1'b1, 5'd1, 5'd2, 13'd8));
        emit_store(5'd31);
        prog.push_back(branch(1'b0, 5'd1, 5'd2, 13'd8));
        emit_store(5'd1);
        prog.push_back(jal(5'd0, 21'd0));
        expect_q = '{32'd11, 32'd3};
        run_program("branch");
    endtask

    task automatic test_jal();
        start_program();
        prog.push_back(jal(5'd1, 21'd8));
        emit_store(5'd31);
        emit_store(5'd1);
        prog.push_back(jal(5'd2, 21'd8));
        emit_store(5'd31);
        emit_store(5'd2);
        prog.push_back(jal(5'd0, 21'd0));
        expect_q = '{32'd8, 32'd20};
        run_program("jal");
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        start_program();
        for (int i = 1; i <= 6; i++) begin
            r = $urandom();
            prog.push_back(addi(i[4:0], 5'd0, r[11:0]));
            expect_q.push_back(sext12(r[11:0]));
        end
        emit_store(5'd1);
        emit_store(5'd2);
        emit_store(5'd3);
        // offset 4 misses the port, so this store must not raise a request.
        prog.push_back(sw(5'd4, 5'd31, 12'd4));
        emit_store(5'd4);
        emit_store(5'd5);
        emit_store(5'd6);
        prog.push_back(jal(5'd0, 21'd0));
        run_program("backpressure");
    endtask

    initial begin
        int assert_fails;
        void'($urandom(32'h97fb_57cd));
        arst_n     <= 1'b0;
        run        <= 1'b0;
        imem_we    <= 1'b0;
        imem_addr  <= '0;
        imem_wdata <= '0;
        io_ack     <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        test_arith();
        test_logic();
        test_deps();
        test_branch();
        test_jal();
        test_backpressure();

        assert_fails = dut.u_assertions.failures;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    exec_if.exec                   x,
    output logic [rv_pkg::xlen-1:0] alu_res
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;

    assign op_a = x.d.rs1_val;
    assign op_b = x.d.use_imm ? x.d.imm : x.d.rs2_val;

    always_comb begin
        case (x.d.alu_op)
            rv_pkg::add:    alu_res = op_a + op_b;
            rv_pkg::sub:    alu_res = op_a - op_b;
            rv_pkg::and_op: alu_res = op_a & op_b;
            rv_pkg::or_op:  alu_res = op_a | op_b;
            rv_pkg::xor_op: alu_res = op_a ^ op_b;
            rv_pkg::slt: begin
                alu_res = {{(rv_pkg::xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            // LUI already has the shifted immediate as its second operand.
            rv_pkg::pass_b: alu_res = op_b;
            default:        alu_res = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    exec_if.exec                    x,
    output logic                    take,
    output logic [rv_pkg::xlen-1:0] target,
    output logic [rv_pkg::xlen-1:0] link
);

    logic equal;
    logic cond;

    assign equal = (x.d.rs1_val == x.d.rs2_val);

    // BEQ and BNE differ only in funct3 bit 0, carried here as branch_ne.
    always_comb begin
        if (x.d.is_jal) begin
            cond = 1'b1;
        end else if (x.d.is_branch) begin
            cond = x.d.branch_ne ? !equal : equal;
        end else begin
            cond = 1'b0;
        end
    end

    assign take   = x.d.valid & cond;
    assign target = x.d.pc + x.d.imm;
    assign link   = x.d.pc + 32'd4;

endmodule

`default_nettype wire

/* logic/exec_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface exec_if;

    rv_pkg::decoded_t        d;
    logic                    stall;
    logic                    flush;
    logic [rv_pkg::xlen-1:0] redirect_pc;
    logic                    wb_en;
    logic [4:0]              wb_rd;
    logic [rv_pkg::xlen-1:0] wb_data;

    modport decode (
        output d,
        input  stall, flush, redirect_pc, wb_en, wb_rd, wb_data
    );

    modport exec (
        input d
    );

    modport wback (
        input  d,
        output stall, flush, redirect_pc, wb_en, wb_rd, wb_data
    );

endinterface

`default_nettype wire

/* logic/fetch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode #(
    parameter int IMEM_DEPTH = rv_pkg::imem_depth_default
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          run,
    input  wire logic                          imem_we,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  wire logic [rv_pkg::xlen-1:0]       imem_wdata,
    exec_if.decode                             x,
    output logic      [rv_pkg::xlen-1:0]       pc_out
);

    localparam int aw = $clog2(IMEM_DEPTH);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] instr;
    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;
    logic [2:0]              funct3;
    rv_pkg::decoded_t        dec;

    // maps funct3 to an ALU operation; sub_en is only set for register-register ops.
    function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                        input logic       sub_en);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = sub_en ? rv_pkg::sub : rv_pkg::add;
            3'b010:  op = rv_pkg::slt;
            3'b100:  op = rv_pkg::xor_op;
            3'b110:  op = rv_pkg::or_op;
            3'b111:  op = rv_pkg::and_op;
            default: op = rv_pkg::add;
        endcase
        return op;
    endfunction

    // ------------------------------------------------------------------------
    // fetch and register read
    // ------------------------------------------------------------------------

    instr_mem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk   (clk),
        .we    (imem_we & ~run),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (pc[aw+1:2]),
        .rdata (instr)
    );

    reg_file u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wb_en   (x.wb_en),
        .wb_rd   (x.wb_rd),
        .wb_data (x.wb_data)
    );

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------

    assign funct3 = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec         = '0;
        dec.valid   = 1'b1;
        dec.alu_op  = rv_pkg::add;
        dec.rs1_val = rs1_val;
        dec.rs2_val = rs2_val;
        dec.pc      = pc;
        dec.rd      = instr[11:7];

        // unknown opcodes pass through with no side effects.
        case (instr[6:0])
            rv_pkg::opc_op: begin
                dec.alu_op    = alu_from_funct3(funct3, instr[30]);
                dec.reg_write = 1'b1;
            end
            rv_pkg::opc_op_imm: begin
                dec.alu_op    = alu_from_funct3(funct3, 1'b0);
                dec.use_imm   = 1'b1;
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
            end
            rv_pkg::opc_lui: begin
                dec.alu_op    = rv_pkg::pass_b;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            rv_pkg::opc_branch: begin
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                dec.imm       = imm_b;
            end
            rv_pkg::opc_jal: begin
                dec.is_jal    = 1'b1;
                dec.imm       = imm_j;
                dec.reg_write = 1'b1;
            end
            rv_pkg::opc_store: begin
                // the ALU forms the store address from rs1 and the offset.
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            default: begin
                dec.reg_write = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // program counter and stage register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= '0;
            x.d <= '0;
        end else if (!run) begin
            pc        <= '0;
            x.d.valid <= 1'b0;
        end else if (x.flush) begin
            // the instruction fetched behind a taken branch is dropped.
            pc        <= x.redirect_pc;
            x.d.valid <= 1'b0;
        end else if (!x.stall) begin
            pc  <= pc + 32'd4;
            x.d <= dec;
        end
    end

    assign pc_out = pc;

endmodule

`default_nettype wire

/* logic/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
    parameter int IMEM_DEPTH = rv_pkg::imem_depth_default
) (
    input  wire logic                          clk,
    input  wire logic                          we,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] waddr,
    input  wire logic [rv_pkg::xlen-1:0]       wdata,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] raddr,
    output logic      [rv_pkg::xlen-1:0]       rdata
);

    logic [rv_pkg::xlen-1:0] mem [IMEM_DEPTH];

    // programs are loaded one word per cycle through the write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // fetch is combinational so decode sees the word in the same cycle.
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic [4:0]              rs1,
    input  wire logic [4:0]              rs2,
    output logic      [rv_pkg::xlen-1:0] rs1_val,
    output logic      [rv_pkg::xlen-1:0] rs2_val,
    input  wire logic                    wb_en,
    input  wire logic [4:0]              wb_rd,
    input  wire logic [rv_pkg::xlen-1:0] wb_data
);

    logic [rv_pkg::xlen-1:0] regs [32];

    // x0 is never written, so it stays at its reset value of zero.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through: a read of the register being written returns the new value,
    // so a dependent instruction right behind the writer needs no bubble.
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1_val = '0;
        end else if (wb_en && (wb_rd == rs1)) begin
            rs1_val = wb_data;
        end else begin
            rs1_val = regs[rs1];
        end

        if (rs2 == 5'd0) begin
            rs2_val = '0;
        end else if (wb_en && (wb_rd == rs2)) begin
            rs2_val = wb_data;
        end else begin
            rs2_val = regs[rs2];
        end
    end

endmodule

`default_nettype wire

/* logic/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter int IMEM_DEPTH = rv_pkg::imem_depth_default
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          run,
    input  wire logic                          imem_we,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  wire logic [rv_pkg::xlen-1:0]       imem_wdata,
    input  wire logic                          io_ack,
    output logic                               io_req,
    output logic      [rv_pkg::xlen-1:0]       io_data,
    output logic      [rv_pkg::xlen-1:0]       pc_out
);

    logic [rv_pkg::xlen-1:0] alu_res;
    logic                    take;
    logic [rv_pkg::xlen-1:0] target;
    logic [rv_pkg::xlen-1:0] link;

    exec_if x_if ();

    // stage 1.
    fetch_decode #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .x          (x_if.decode),
        .pc_out     (pc_out)
    );

    // stage 2 units work side by side on the same decoded instruction.
    alu_unit u_alu (
        .x       (x_if.exec),
        .alu_res (alu_res)
    );

    branch_unit u_branch (
        .x      (x_if.exec),
        .take   (take),
        .target (target),
        .link   (link)
    );

    writeback_sel #(
        .IO_ADDR (rv_pkg::io_addr)
    ) u_writeback (
        .clk     (clk),
        .arst_n  (arst_n),
        .x       (x_if.wback),
        .alu_res (alu_res),
        .take    (take),
        .target  (target),
        .link    (link),
        .io_req  (io_req),
        .io_data (io_data),
        .io_ack  (io_ack)
    );

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // ------------------------------------------------------------------------
    // widths and fixed addresses
    // ------------------------------------------------------------------------

    localparam int xlen = 32;
    localparam int imem_depth_default = 64;

    // byte address of the memory-mapped output port.
    localparam logic [xlen-1:0] io_addr = 32'h0000_0100;

    // ------------------------------------------------------------------------
    // RV32I opcodes used by this core
    // ------------------------------------------------------------------------

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_store  = 7'b0100011;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        slt,
        pass_b
    } alu_op_e;

    // everything stage 2 needs, captured by the stage register.
    typedef struct packed {
        logic            valid;
        alu_op_e         alu_op;
        logic            use_imm;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            reg_write;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            is_store;
    } decoded_t;

endpackage

`default_nettype wire

/* logic/writeback_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_sel #(
    parameter logic [rv_pkg::xlen-1:0] IO_ADDR = rv_pkg::io_addr
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    exec_if.wback                        x,
    input  wire logic [rv_pkg::xlen-1:0] alu_res,
    input  wire logic                    take,
    input  wire logic [rv_pkg::xlen-1:0] target,
    input  wire logic [rv_pkg::xlen-1:0] link,
    output logic                         io_req,
    output logic      [rv_pkg::xlen-1:0] io_data,
    input  wire logic                    io_ack
);

    typedef enum logic [1:0] {
        idle,
        wait_ack_hi,
        wait_ack_lo
    } hs_state_e;

    hs_state_e state;
    logic      io_store;
    logic      retire;

    // ------------------------------------------------------------------------
    // output port handshake
    // ------------------------------------------------------------------------

    assign io_store = x.d.valid & x.d.is_store & (alu_res == IO_ADDR);

    // the store leaves stage 2 on the edge where ack is seen low after the drop.
    assign retire = (state == wait_ack_lo) && !io_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (io_store && !io_ack) begin
                        state <= wait_ack_hi;
                    end
                end
                wait_ack_hi: begin
                    if (io_ack) begin
                        state <= wait_ack_lo;
                    end
                end
                wait_ack_lo: begin
                    if (!io_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle) begin
            io_data <= x.d.rs2_val;
        end
    end

    assign io_req  = (state == wait_ack_hi);
    assign x.stall = io_store & !retire;

    // ------------------------------------------------------------------------
    // register write and redirect
    // ------------------------------------------------------------------------

    assign x.flush       = take;
    assign x.redirect_pc = target;

    assign x.wb_en   = x.d.valid & x.d.reg_write & !x.stall & (x.d.rd != 5'd0);
    assign x.wb_rd   = x.d.rd;
    assign x.wb_data = x.d.is_jal ? link : alu_res;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_tb -f sources.f -o Vrv_tb

# assertion failures are counted by the testbench, so the run must not stop at the first one.
./obj_dir/Vrv_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sources.f */
logic/rv_pkg.sv
logic/exec_if.sv
logic/instr_mem.sv
logic/reg_file.sv
logic/fetch_decode.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/writeback_sel.sv
logic/rv_core_top.sv
dv/rv_assertions.sv
dv/rv_tb.sv
